/* Makefile */
# Verilator build and run of the VGA scan-out testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module tb_vga -f verilog.f -o sim_vga
	./obj_dir/sim_vga > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* design/axil_fb_port.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module axil_fb_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,      // not applied, a pixel is one whole word
    output logic                bvalid,
    input  logic                bready,
    output bus_pkg::axi_resp_t  bresp,
    input  logic                arvalid,
    output logic                arready,
    input  logic [31:0]         araddr,
    output logic                rvalid,
    input  logic                rready,
    output logic [31:0]         rdata,
    output bus_pkg::axi_resp_t  rresp,
    output logic                host_req,
    output logic                host_we,
    output video_pkg::fb_addr_t host_addr,
    output video_pkg::pixel_t   host_wdata,
    input  logic                host_ack,
    input  video_pkg::pixel_t   host_rdata
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

    state_t      state;
    logic        aw_got;        // write address captured
    logic        w_got;         // write data captured
    logic [29:0] aw_word;       // byte address / 4
    logic        wr_ok;
    logic        rd_ok;

    // range checks on word addresses
    assign wr_ok = aw_word < 30'(`FB_DEPTH);
    assign rd_ok = araddr[31:2] < 30'(`FB_DEPTH);

    assign awready = (state == ST_IDLE) && !aw_got;
    assign wready  = (state == ST_IDLE) && !w_got;
    // a pending or half-captured write keeps reads out
    assign arready = (state == ST_IDLE) && !aw_got && !w_got && !awvalid && !wvalid;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= ST_IDLE;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            host_req <= 1'b0;
            host_we  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (awvalid && awready)
                    begin
                        aw_got  <= 1'b1;
                        aw_word <= awaddr[31:2];
                    end
                    if (wvalid && wready)
                    begin
                        w_got      <= 1'b1;
                        host_wdata <= video_pkg::pixel_t'(wdata[11:0]); // upper bits dropped
                    end
                    if (aw_got && w_got)                    // both halves in, launch write
                    begin
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                        if (wr_ok)
                        begin
                            host_req  <= 1'b1;
                            host_we   <= 1'b1;
                            host_addr <= aw_word[18:0];
                            state     <= ST_REQ;
                        end
                        else
                        begin
                            bvalid <= 1'b1;                 // no RAM access at all
                            bresp  <= bus_pkg::RESP_SLVERR;
                            state  <= ST_RESP;
                        end
                    end
                    else if (arvalid && arready)
                    begin
                        if (rd_ok)
                        begin
                            host_req  <= 1'b1;
                            host_we   <= 1'b0;
                            host_addr <= araddr[20:2];
                            state     <= ST_REQ;
                        end
                        else
                        begin
                            rvalid <= 1'b1;
                            rdata  <= 32'd0;
                            rresp  <= bus_pkg::RESP_SLVERR;
                            state  <= ST_RESP;
                        end
                    end
                end
                ST_REQ:
                begin
                    if (host_ack)                           // may wait behind the fetcher
                    begin
                        host_req <= 1'b0;
                        if (host_we)
                        begin
                            bvalid <= 1'b1;
                            bresp  <= bus_pkg::RESP_OKAY;
                        end
                        else
                        begin
                            rvalid <= 1'b1;
                            rdata  <= {20'd0, host_rdata};  // zero-extend
                            rresp  <= bus_pkg::RESP_OKAY;
                        end
                        state <= ST_RESP;
                    end
                end
                ST_RESP:
                begin
                    // hold the response until the master takes it
                    if ((bvalid && bready) || (rvalid && rready))
                    begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a waiting request must not move until the arbiter takes it
    req_held: assert property (@(posedge clk) disable iff (!rst)
        host_req && !host_ack |=> host_req && $stable(host_addr) && $stable(host_we)
                                 && $stable(host_wdata));

endmodule

/* design/bus_pkg.sv */
package bus_pkg;

    // AXI4-Lite response codes, only the two we ever send
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10    // address past the framebuffer
    } axi_resp_t;

    // who owns the RAM port this cycle
    typedef enum logic [1:0] {
        GNT_NONE  = 2'b00,
        GNT_FETCH = 2'b01,     // scan-out, always first
        GNT_HOST  = 2'b10
    } grant_t;

endpackage

/* design/fb_arbiter.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module fb_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_req,
    input  video_pkg::fb_addr_t fetch_addr,
    output logic                fetch_rvalid,
    output video_pkg::pixel_t   fetch_rdata,
    input  logic                host_req,
    input  logic                host_we,
    input  video_pkg::fb_addr_t host_addr,
    input  video_pkg::pixel_t   host_wdata,
    output logic                host_ack,
    output video_pkg::pixel_t   host_rdata
);

    video_pkg::pixel_t   mem [0:`FB_DEPTH-1];  // whole frame, row-major
    bus_pkg::grant_t     grant;
    video_pkg::fb_addr_t port_addr;            // the one address into the RAM
    video_pkg::pixel_t   port_rd;

    // fetcher has a deadline, host just waits a cycle
    always_comb
    begin
        if (fetch_req)
            grant = bus_pkg::GNT_FETCH;
        else if (host_req)
            grant = bus_pkg::GNT_HOST;
        else
            grant = bus_pkg::GNT_NONE;
    end

    assign port_addr  = (grant == bus_pkg::GNT_HOST) ? host_addr : fetch_addr;
    assign port_rd    = mem[port_addr];

    // host access completes in its grant cycle
    assign host_ack   = (grant == bus_pkg::GNT_HOST);
    assign host_rdata = port_rd;       // valid alongside host_ack

    always_ff @(posedge clk)
    begin
        if (host_ack && host_we)
            mem[port_addr] <= host_wdata;
    end

    // fetch data lands one cycle after the request
    always_ff @(posedge clk)
    begin
        if (grant == bus_pkg::GNT_FETCH)
            fetch_rdata <= port_rd;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            fetch_rvalid <= 1'b0;
        else
            fetch_rvalid <= (grant == bus_pkg::GNT_FETCH);
    end

    // priority: a fetch cycle never serves the host
    no_host_on_fetch: assert property (@(posedge clk) disable iff (!rst)
        fetch_req |-> !host_ack);

    // scan-out relies on a fixed one-cycle return
    fetch_returns: assert property (@(posedge clk) disable iff (!rst)
        fetch_req |=> fetch_rvalid);

endmodule

/* design/scan_fetch.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module scan_fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    input  video_pkg::h_pos_t   h_count,
    input  video_pkg::v_pos_t   v_count,
    output logic                fetch_req,
    output video_pkg::fb_addr_t fetch_addr,
    input  logic                fetch_rvalid,
    input  video_pkg::pixel_t   fetch_rdata,
    input  logic [4:0]          grp_rd_idx,
    output video_pkg::pixel_t   grp_rd_pix
);

    // two halves of one group each, picked by group parity
    video_pkg::pixel_t grp_mem [0:1][0:`GROUP_W-1];

    video_pkg::h_pos_t col;           // column fetched at this tick
    video_pkg::group_t fetch_grp;
    logic              in_window;
    logic              wr_half;       // half of the pending read
    logic [4:0]        wr_idx;
    logic              rd_half;

    // fetch runs 32 ticks ahead of the beam
    assign col       = h_count - video_pkg::h_pos_t'(`FETCH_START);
    assign fetch_grp = col[9:5];
    assign in_window = (v_count < video_pkg::v_pos_t'(`VA_END))
                    && (h_count >= video_pkg::h_pos_t'(`FETCH_START))
                    && (h_count < video_pkg::h_pos_t'(`FETCH_START + `FB_W));

    // one-cycle strobe, always in the clk after a tick
    always_ff @(posedge clk)
    begin
        if (!rst)
            fetch_req <= 1'b0;
        else
            fetch_req <= tick && in_window;
    end

    // address and destination held until the data returns
    always_ff @(posedge clk)
    begin
        if (tick && in_window)
        begin
            fetch_addr <= video_pkg::fb_index(col, v_count);
            wr_half    <= fetch_grp[0];    // back half while this group loads
            wr_idx     <= col[4:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_rvalid)
            grp_mem[wr_half][wr_idx] <= fetch_rdata;
    end

    // front half flips every 32 ticks
    // display group (h-160)/32 is odd exactly when h[5] is low
    assign rd_half    = ~h_count[5];
    assign grp_rd_pix = grp_mem[rd_half][grp_rd_idx];

endmodule

/* design/vga_config.svh */
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// 640x480 at one pixel tick per two clk
`define H_TOTAL     800             // ticks per line
`define V_TOTAL     525             // lines per frame

// horizontal, counted in ticks from the start of the line
`define HS_START    16              // front porch ends, hs goes low
`define HS_END      112             // 96 tick sync pulse
`define HA_START    160             // after 48 tick back porch

// vertical, counted in lines
`define VA_END      480             // active lines
`define VS_START    490
`define VS_END      492             // two line sync pulse

// framebuffer geometry
`define FB_W        640
`define FB_H        480
`define FB_DEPTH    (`FB_W * `FB_H) // one word per pixel

// scan-out fetch
`define GROUP_W     32              // pixels per group
`define FETCH_START 128             // one group ahead of HA_START

`endif

/* design/vga_timing.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output logic              tick,
    output video_pkg::h_pos_t h_count,
    output video_pkg::v_pos_t v_count,
    output logic [4:0]        grp_rd_idx,
    input  video_pkg::pixel_t grp_rd_pix,
    output logic              hs,
    output logic              vs,
    output logic [3:0]        rval,
    output logic [3:0]        gval,
    output logic [3:0]        bval,
    output logic              vblank
);

    video_pkg::h_pos_t x;      // column inside the active area
    logic              active;
    logic              h_last;
    logic              v_last;
    logic              hs_on;
    logic              vs_on;

    assign x          = h_count - video_pkg::h_pos_t'(`HA_START);
    assign grp_rd_idx = x[4:0];            // HA_START is group aligned
    assign active     = (h_count >= video_pkg::h_pos_t'(`HA_START))
                     && (v_count < video_pkg::v_pos_t'(`VA_END));
    assign h_last     = (h_count == video_pkg::h_pos_t'(`H_TOTAL - 1));
    assign v_last     = (v_count == video_pkg::v_pos_t'(`V_TOTAL - 1));
    assign hs_on      = (h_count >= video_pkg::h_pos_t'(`HS_START))
                     && (h_count < video_pkg::h_pos_t'(`HS_END));
    assign vs_on      = (v_count >= video_pkg::v_pos_t'(`VS_START))
                     && (v_count < video_pkg::v_pos_t'(`VS_END));

    // divide by two, first clk out of reset is a tick
    always_ff @(posedge clk)
    begin
        if (!rst)
            tick <= 1'b1;
        else
            tick <= ~tick;
    end

    // beam position
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (tick)
        begin
            if (h_last)                    // wrap line
            begin
                h_count <= '0;
                v_count <= v_last ? '0 : v_count + 1'b1;
            end
            else
                h_count <= h_count + 1'b1;
        end
    end

    // all outputs sampled from the position before the step
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            hs     <= 1'b1;
            vs     <= 1'b1;
            rval   <= 4'd0;
            gval   <= 4'd0;
            bval   <= 4'd0;
            vblank <= 1'b0;
        end
        else if (tick)
        begin
            hs     <= ~hs_on;              // negative sync
            vs     <= ~vs_on;
            vblank <= (v_count >= video_pkg::v_pos_t'(`VA_END));
            rval   <= active ? grp_rd_pix.r : 4'd0;   // black outside active area
            gval   <= active ? grp_rd_pix.g : 4'd0;
            bval   <= active ? grp_rd_pix.b : 4'd0;
        end
    end

    // fetch window math assumes the line never overruns
    h_in_range: assert property (@(posedge clk) disable iff (!rst)
        h_count < video_pkg::h_pos_t'(`H_TOTAL));

endmodule

/* design/vga_top.sv */
`timescale 1ns/1ns

module vga_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output bus_pkg::axi_resp_t bresp,
    input  logic               arvalid,
    output logic               arready,
    input  logic [31:0]        araddr,
    output logic               rvalid,
    input  logic               rready,
    output logic [31:0]        rdata,
    output bus_pkg::axi_resp_t rresp,
    output logic               hs,
    output logic               vs,
    output logic [3:0]         rval,
    output logic [3:0]         gval,
    output logic [3:0]         bval,
    output logic               vblank
);

    // host side
    logic                host_req, host_we, host_ack;
    video_pkg::fb_addr_t host_addr;
    video_pkg::pixel_t   host_wdata, host_rdata;
    // scan-out side
    logic                fetch_req, fetch_rvalid, tick;
    video_pkg::fb_addr_t fetch_addr;
    video_pkg::pixel_t   fetch_rdata, grp_rd_pix;
    video_pkg::h_pos_t   h_count;
    video_pkg::v_pos_t   v_count;
    logic [4:0]          grp_rd_idx;

    axil_fb_port port_i (.*);     // AXI4-Lite to host request

    fb_arbiter arb_i (.*);        // RAM, fetch first

    scan_fetch fetch_i (.*);      // group store, one group ahead

    vga_timing timing_i (.*);     // beam, sync and colour out

endmodule

/* design/video_pkg.sv */
`include "vga_config.svh"

package video_pkg;

    // 12-bit BGR, blue in the top nibble
    typedef struct packed {
        logic [3:0] b;
        logic [3:0] g;
        logic [3:0] r;
    } pixel_t;

    typedef logic [9:0]  h_pos_t;   // tick within the line, 0..799
    typedef logic [9:0]  v_pos_t;   // line within the frame, 0..524

    typedef logic [18:0] fb_addr_t; // word address, covers 307200 pixels

    typedef logic [4:0]  group_t;   // group number within a line, 0..19

    // row-major word address of pixel (x, y)
    function automatic fb_addr_t fb_index(input h_pos_t x, input v_pos_t y);
        fb_addr_t row_base;
        row_base = fb_addr_t'(y) * fb_addr_t'(`FB_W);
        return row_base + fb_addr_t'(x);
    endfunction

endpackage

/* tb/tb_vga.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module tb_vga;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT, OP_BURST} op_t;

    // for OP_BURST the x column is the number of random writes
    typedef struct packed {
        op_t                op;
        logic [9:0]         x;
        logic [9:0]         y;
        logic [11:0]        colour;     // b, g, r nibbles
        bus_pkg::axi_resp_t resp;
    } row_t;

    localparam int ROWS      = 17;
    localparam int FRAME_CLK = 2 * `H_TOTAL * `V_TOTAL;
    localparam int LIMIT     = ROWS * 2 * FRAME_CLK + 100000;  // two frames a row, plus slack

    logic               clk, rst;
    logic               awvalid, awready, wvalid, wready, bvalid, bready;
    logic               arvalid, arready, rvalid, rready;
    logic [31:0]        awaddr, wdata, araddr, rdata;
    logic [3:0]         wstrb;
    bus_pkg::axi_resp_t bresp, rresp, exp_resp;
    logic               hs, vs, vblank;
    logic [3:0]         rval, gval, bval;
    logic               row_done, run_done, stress;
    int                 row_num, err_count, cycles;
    row_t               rows [0:ROWS-1];

    vga_top dut_i (.*);

    vga_checker checker_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d clk cycles", cycles);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] pixel_addr(input int x, input int y);
        return 32'((y * `FB_W + x) * 4);    // byte address, one word per pixel
    endfunction

    function automatic logic pick_ready();
        return stress ? 1'($urandom_range(0, 1)) : 1'b1;   // back-pressure only under load
    endfunction

    task automatic load_table();
        rows[0]  = '{OP_WRITE, 10'd0,   10'd0,    12'h00f, bus_pkg::RESP_OKAY};  // corners
        rows[1]  = '{OP_WRITE, 10'd639, 10'd0,    12'h0f0, bus_pkg::RESP_OKAY};
        rows[2]  = '{OP_WRITE, 10'd0,   10'd479,  12'hf00, bus_pkg::RESP_OKAY};
        rows[3]  = '{OP_WRITE, 10'd639, 10'd479,  12'hfff, bus_pkg::RESP_OKAY};
        rows[4]  = '{OP_WRITE, 10'd31,  10'd100,  12'h5a3, bus_pkg::RESP_OKAY};  // group edge
        rows[5]  = '{OP_WRITE, 10'd32,  10'd100,  12'h3c7, bus_pkg::RESP_OKAY};
        rows[6]  = '{OP_WRITE, 10'd0,   10'd480,  12'h123, bus_pkg::RESP_SLVERR}; // first bad word
        rows[7]  = '{OP_WRITE, 10'd639, 10'd1023, 12'h456, bus_pkg::RESP_SLVERR};
        rows[8]  = '{OP_READ,  10'd0,   10'd0,    12'h000, bus_pkg::RESP_OKAY};
        rows[9]  = '{OP_READ,  10'd639, 10'd479,  12'h000, bus_pkg::RESP_OKAY};
        rows[10] = '{OP_READ,  10'd32,  10'd100,  12'h000, bus_pkg::RESP_OKAY};
        rows[11] = '{OP_READ,  10'd0,   10'd480,  12'h000, bus_pkg::RESP_SLVERR};
        rows[12] = '{OP_WAIT,  10'd0,   10'd0,    12'h000, bus_pkg::RESP_OKAY};
        rows[13] = '{OP_WAIT,  10'd0,   10'd0,    12'h000, bus_pkg::RESP_OKAY};  // frame shown
        rows[14] = '{OP_BURST, 10'd24,  10'd0,    12'h000, bus_pkg::RESP_OKAY};
        rows[15] = '{OP_WAIT,  10'd0,   10'd0,    12'h000, bus_pkg::RESP_OKAY};
        rows[16] = '{OP_WAIT,  10'd0,   10'd0,    12'h000, bus_pkg::RESP_OKAY};
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        logic aw_done;
        logic w_done;
        logic hit;
        aw_done = 1'b0;
        w_done  = 1'b0;
        hit     = 1'b0;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        while (!(aw_done && w_done))        // the port takes aw and w in any order
        begin
            @(posedge clk);
            if (awvalid && awready)
            begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready)
            begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        bready <= pick_ready();
        while (!hit)
        begin
            @(posedge clk);
            hit = bvalid && bready;
            bready <= hit ? 1'b0 : pick_ready();
        end
    endtask

    task automatic axi_read(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        araddr  <= addr;
        arvalid <= 1'b1;
        while (!hit)
        begin
            @(posedge clk);
            hit = arvalid && arready;
        end
        arvalid <= 1'b0;
        hit = 1'b0;
        rready <= pick_ready();
        while (!hit)
        begin
            @(posedge clk);
            hit = rvalid && rready;
            rready <= hit ? 1'b0 : pick_ready();
        end
    endtask

    // random writes during active scan, then read every one back
    task automatic run_burst(input int len);
        logic [31:0] addrs [$];
        logic [31:0] a;
        while (vblank)
            @(posedge clk);
        stress = 1'b1;
        repeat (len)
        begin
            a = pixel_addr($urandom_range(0, `FB_W - 1), $urandom_range(0, `FB_H - 1));
            addrs.push_back(a);
            axi_write(a, $urandom());       // only bits 11:0 land
        end
        foreach (addrs[k])
            axi_read(addrs[k]);
        stress = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'h7c2c));
        rst      = 1'b0;
        awvalid  = 1'b0;
        awaddr   = 32'd0;
        wvalid   = 1'b0;
        wdata    = 32'd0;
        wstrb    = 4'hf;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = 32'd0;
        rready   = 1'b0;
        exp_resp = bus_pkg::RESP_OKAY;
        row_num  = 0;
        row_done = 1'b0;
        run_done = 1'b0;
        stress   = 1'b0;
        load_table();
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < ROWS; i++)
        begin
            exp_resp <= rows[i].resp;
            case (rows[i].op)
                OP_WRITE: axi_write(pixel_addr(rows[i].x, rows[i].y),
                                    {20'($urandom()), rows[i].colour});
                OP_READ:  axi_read(pixel_addr(rows[i].x, rows[i].y));
                OP_WAIT:
                begin
                    @(negedge vs);          // next frame boundary
                    @(posedge clk);
                end
                default:  run_burst(rows[i].x);
            endcase
            row_num  <= i;
            row_done <= 1'b1;
            @(posedge clk);
            row_done <= 1'b0;
        end
        run_done <= 1'b1;
        repeat (2) @(posedge clk);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* tb/vga_checker.sv */
`timescale 1ns/1ns
`include "vga_config.svh"

module vga_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid,
    input  logic               awready,
    input  logic [31:0]        awaddr,
    input  logic               wvalid,
    input  logic               wready,
    input  logic [31:0]        wdata,
    input  logic               bvalid,
    input  logic               bready,
    input  bus_pkg::axi_resp_t bresp,
    input  logic               arvalid,
    input  logic               arready,
    input  logic [31:0]        araddr,
    input  logic               rvalid,
    input  logic               rready,
    input  logic [31:0]        rdata,
    input  bus_pkg::axi_resp_t rresp,
    input  logic               hs,
    input  logic               vs,
    input  logic [3:0]         rval,
    input  logic [3:0]         gval,
    input  logic [3:0]         bval,
    input  logic               vblank,
    input  bus_pkg::axi_resp_t exp_resp,    // response the current row expects
    input  int                 row_num,
    input  logic               row_done,
    input  logic               run_done,
    output int                 err_count
);

    localparam int LINE_CLK  = 2 * `H_TOTAL;                    // 1600 clk per line
    localparam int ACT_FIRST = 2 * (`HA_START - `HS_START);     // pixel 0 counted from hs fall
    localparam int ACT_END   = ACT_FIRST + 2 * `FB_W;

    video_pkg::pixel_t fb_model [int];    // word address -> last OKAY write
    int                fb_epoch [int];    // frame count when that write finished
    logic [31:0]       aw_q, w_q, ar_q;
    logic              hs_q, vs_q, hs_seen, vs_seen, line_ok, closed;
    int                since_hs, since_vs, cur_line, epoch;
    int                row_errs, passed, failed;

    task automatic report_mismatch(input string msg);
        $display("MISMATCH @%0t: %s", $time, msg);
        err_count++;
        row_errs++;
    endtask

    task automatic check_bus();
        int          a;
        logic [31:0] want;
        logic        known;
        if (awvalid && awready) aw_q = awaddr;
        if (wvalid && wready) w_q = wdata;
        if (arvalid && arready) ar_q = araddr;
        if (bvalid && bready)
        begin
            if (bresp != exp_resp)
                report_mismatch($sformatf("write %08h got %s, expected %s",
                                          aw_q, bresp.name(), exp_resp.name()));
            if (bresp == bus_pkg::RESP_OKAY)
            begin
                a = int'(aw_q >> 2);
                fb_model[a] = video_pkg::pixel_t'(w_q[11:0]);   // bits above 11 dropped
                fb_epoch[a] = epoch;
            end
        end
        if (rvalid && rready)
        begin
            a = int'(ar_q >> 2);
            known = 1'b1;
            want  = 32'd0;
            if (ar_q[31:2] >= 30'(`FB_DEPTH))
                want = 32'd0;                       // out of range reads as zero
            else if (fb_model.exists(a))
                want = {20'd0, fb_model[a]};
            else
                known = 1'b0;
            if (rresp != exp_resp)
                report_mismatch($sformatf("read %08h got %s, expected %s",
                                          ar_q, rresp.name(), exp_resp.name()));
            if (known && rdata !== want)
                report_mismatch($sformatf("read %08h data %08h, expected %08h",
                                          ar_q, rdata, want));
        end
    endtask

    // line number follows the hs and vs edges
    // vs falls in line 490
    task automatic track_sync();
        if (hs_q && !hs)
        begin
            if (hs_seen && since_hs + 1 != LINE_CLK)
                report_mismatch($sformatf("line of %0d clk", since_hs + 1));
            hs_seen  = 1'b1;
            since_hs = 0;
            if (line_ok)
            begin
                cur_line = (cur_line == `V_TOTAL - 1) ? 0 : cur_line + 1;
                if (vblank != (cur_line >= `VA_END))
                    report_mismatch($sformatf("vblank %0b in line %0d", vblank, cur_line));
            end
        end
        else
            since_hs++;
        if (!hs_q && hs && since_hs != 2 * (`HS_END - `HS_START))
            report_mismatch($sformatf("hs low for %0d clk", since_hs));
        if (vs_q && !vs)
        begin
            if (vs_seen && since_vs + 1 != LINE_CLK * `V_TOTAL)
                report_mismatch($sformatf("frame of %0d clk", since_vs + 1));
            vs_seen  = 1'b1;
            since_vs = 0;
            cur_line = `VS_START - 1;       // bumped at the next hs fall
            line_ok  = 1'b1;
            epoch++;
        end
        else
            since_vs++;
        if (!vs_q && vs && vs_seen && since_vs != LINE_CLK * (`VS_END - `VS_START))
            report_mismatch($sformatf("vs low for %0d clk", since_vs));
    endtask

    task automatic check_colour();
        video_pkg::pixel_t seen;
        int                x;
        int                a;
        seen.b = bval;
        seen.g = gval;
        seen.r = rval;
        x = (since_hs - ACT_FIRST) / 2;     // each pixel holds 2 clk
        a = cur_line * `FB_W + x;
        if (since_hs < ACT_FIRST || since_hs >= ACT_END || (line_ok && cur_line >= `VA_END))
        begin
            if (hs_seen && seen != '0)
                report_mismatch($sformatf("colour %03h in blanking", seen));
        end
        else if (line_ok && fb_model.exists(a) && fb_epoch[a] < epoch && seen != fb_model[a])
            report_mismatch($sformatf("pixel (%0d,%0d) shows %03h, expected %03h",
                                      x, cur_line, seen, fb_model[a]));
    endtask

    // outputs move on posedge so negedge sees them settled
    always @(negedge clk)
    begin
        if (!rst)
        begin
            hs_q    = 1'b1;
            vs_q    = 1'b1;
            hs_seen = 1'b0;
            vs_seen = 1'b0;
            line_ok = 1'b0;
            closed  = 1'b0;
        end
        else
        begin
            check_bus();
            track_sync();
            check_colour();
            hs_q = hs;
            vs_q = vs;
            if (row_done)
            begin
                $display("test %0d: %s, %0d mismatches", row_num,
                         (row_errs == 0) ? "ok" : "FAIL", row_errs);
                if (row_errs == 0)
                    passed++;
                else
                    failed++;
                row_errs = 0;
            end
            if (run_done && !closed)
            begin
                closed = 1'b1;
                $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
                         passed + failed, passed, failed, err_count);
            end
        end
    end

endmodule

/* verilog.f */
+incdir+design
design/video_pkg.sv
design/bus_pkg.sv
design/axil_fb_port.sv
design/fb_arbiter.sv
design/scan_fetch.sv
design/vga_timing.sv
design/vga_top.sv
tb/vga_checker.sv
tb/tb_vga.sv
